// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/cpu_reg.sv
      - src/cpu_alu.sv
      - src/cpu_pc.sv
      - src/cpu_idec.sv
      - src/cpu_sequencer.sv
      - src/cpu.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/cpu_tb.sv

// ==== src.f ====
+incdir+src
src/cpu_pkg.sv
src/cpu_reg.sv
src/cpu_alu.sv
src/cpu_pc.sv
src/cpu_idec.sv
src/cpu_sequencer.sv
src/cpu.sv
verif/cpu_tb.sv

// ==== src/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic           clk_i,
	input  logic           arst_n_i,
	output cpu_pkg::addr_t addr_o,
	input  cpu_pkg::data_t data_i,
	output cpu_pkg::data_t data_o,
	output logic           we_o,
	output logic           halted_o
);

	import cpu_pkg::*;

	data_t      ir;
	data_t      acc;
	data_t      x;
	data_t      dll;
	data_t      dlh;
	data_t      idec_byte;
	data_t      alu_a;
	data_t      alu_b;
	data_t      alu_y;
	status_t    p;
	status_t    p_next;
	status_t    alu_flags;
	status_t    flags_mask;
	addr_t      pc;
	addr_t      jmp_addr;
	logic       ir_we;
	logic       a_we;
	logic       x_we;
	logic       p_we;
	logic       dll_we;
	logic       dlh_we;
	logic       carry_set;
	logic       carry_clr;
	logic       pc_inc;
	logic       pc_load;
	alu_func_t  alu_func;
	alu_a_sel_t alu_a_sel;
	alu_b_sel_t alu_b_sel;
	addr_sel_t  addr_sel;
	opcode_t    opcode;
	mode_t      mode;

	// Registers
	cpu_reg #(.T(data_t)) ir_reg (.clk_i, .arst_n_i, .we_i(ir_we), .d_i(data_i), .q_o(ir));
	cpu_reg #(.T(data_t)) acc_reg (.clk_i, .arst_n_i, .we_i(a_we), .d_i(alu_y), .q_o(acc));
	cpu_reg #(.T(data_t)) x_reg (.clk_i, .arst_n_i, .we_i(x_we), .d_i(alu_y), .q_o(x));
	cpu_reg #(.T(data_t)) dll_reg (.clk_i, .arst_n_i, .we_i(dll_we), .d_i(data_i), .q_o(dll));
	cpu_reg #(.T(data_t)) dlh_reg (.clk_i, .arst_n_i, .we_i(dlh_we), .d_i(data_i), .q_o(dlh));
	cpu_reg #(.T(status_t)) p_reg (.clk_i, .arst_n_i, .we_i(p_we), .d_i(p_next), .q_o(p));

	// Operand muxes
	always_comb begin
		case (alu_a_sel)
			A_SEL_ACC: alu_a = acc;
			A_SEL_X: alu_a = x;
			default: alu_a = '0;
		endcase
		alu_b = (alu_b_sel == B_SEL_DATA) ? data_i : '0;
	end

	cpu_alu alu0 (
		.func_i(alu_func), .a_i(alu_a), .b_i(alu_b), .cin_i(p.c),
		.y_o(alu_y), .flags_o(alu_flags)
	);

	// Only masked flags change, then SEC/CLC
	always_comb begin
		p_next = status_t'((p & ~flags_mask) | (alu_flags & flags_mask));
		if (carry_set) begin
			p_next.c = 1'b1;
		end
		if (carry_clr) begin
			p_next.c = 1'b0;
		end
	end

	assign jmp_addr = {data_i, dll};

	cpu_pc pc0 (
		.clk_i, .arst_n_i, .inc_i(pc_inc), .load_i(pc_load),
		.load_addr_i(jmp_addr), .pc_o(pc)
	);

	// Decode the bus byte while it is being fetched
	assign idec_byte = ir_we ? data_i : ir;

	cpu_idec idec0 (.ir_i(idec_byte), .opcode_o(opcode), .mode_o(mode));

	cpu_sequencer seq0 (
		.clk_i, .arst_n_i, .opcode_i(opcode), .mode_i(mode),
		.ir_we_o(ir_we), .a_we_o(a_we), .x_we_o(x_we), .p_we_o(p_we),
		.flags_mask_o(flags_mask), .carry_set_o(carry_set), .carry_clr_o(carry_clr),
		.dll_we_o(dll_we), .dlh_we_o(dlh_we), .pc_inc_o(pc_inc), .pc_load_o(pc_load),
		.alu_func_o(alu_func), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel),
		.addr_sel_o(addr_sel), .we_o(we_o), .halted_o(halted_o)
	);

	assign addr_o = (addr_sel == ADDR_SEL_DL) ? {dlh, dll} : pc;
	assign data_o = acc;

endmodule

`default_nettype wire

// ==== src/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_alu (
	input  cpu_pkg::alu_func_t func_i,
	input  cpu_pkg::data_t     a_i,
	input  cpu_pkg::data_t     b_i,
	input  logic               cin_i,
	output cpu_pkg::data_t     y_o,
	output cpu_pkg::status_t   flags_o
);

	import cpu_pkg::*;

	data_t                b_add;
	logic [`CPU_DATA_N:0] sum;
	logic                 carry;

	always_comb begin
		// Subtract is add with inverted B, borrow is the inverted carry
		b_add = (func_i == ALU_SBC) ? ~b_i : b_i;
		sum = {1'b0, a_i} + {1'b0, b_add} + {{`CPU_DATA_N{1'b0}}, cin_i};
		carry = cin_i;

		case (func_i)
			ALU_PASS_B: y_o = b_i;
			ALU_ADC, ALU_SBC: begin
				y_o = sum[`CPU_DATA_N - 1:0];
				carry = sum[`CPU_DATA_N];
			end
			ALU_AND: y_o = a_i & b_i;
			ALU_ORA: y_o = a_i | b_i;
			ALU_EOR: y_o = a_i ^ b_i;
			ALU_INC_A: y_o = a_i + data_t'(1);
			default: y_o = b_i;
		endcase

		flags_o.n = y_o[`CPU_DATA_N - 1];
		// Same operand signs but result sign differs
		flags_o.v = (a_i[`CPU_DATA_N - 1] == b_add[`CPU_DATA_N - 1]) &&
			(y_o[`CPU_DATA_N - 1] != a_i[`CPU_DATA_N - 1]);
		flags_o.z = (y_o == '0);
		flags_o.c = carry;
	end

endmodule

`default_nettype wire

// ==== src/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bus widths
`define CPU_DATA_N 8
`define CPU_ADDR_N 16

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

// Opcode bytes, 6502 encodings
`define CPU_OP_LDA_IMM 8'hA9
`define CPU_OP_LDA_ABS 8'hAD
`define CPU_OP_STA_ABS 8'h8D
`define CPU_OP_ADC_IMM 8'h69
`define CPU_OP_SBC_IMM 8'hE9
`define CPU_OP_AND_IMM 8'h29
`define CPU_OP_ORA_IMM 8'h09
`define CPU_OP_EOR_IMM 8'h49
`define CPU_OP_TAX     8'hAA
`define CPU_OP_INX     8'hE8
`define CPU_OP_SEC     8'h38
`define CPU_OP_CLC     8'h18
`define CPU_OP_JMP_ABS 8'h4C
`define CPU_OP_BRK     8'h00

`endif

// ==== src/cpu_idec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_idec (
	input  cpu_pkg::data_t   ir_i,
	output cpu_pkg::opcode_t opcode_o,
	output cpu_pkg::mode_t   mode_o
);

	import cpu_pkg::*;

	always_comb begin
		opcode_o = OP_ILLEGAL;
		mode_o = MODE_IMP;

		case (ir_i)
			`CPU_OP_LDA_IMM: begin
				opcode_o = OP_LDA;
				mode_o = MODE_IMM;
			end
			`CPU_OP_LDA_ABS: begin
				opcode_o = OP_LDA;
				mode_o = MODE_ABS;
			end
			`CPU_OP_STA_ABS: begin
				opcode_o = OP_STA;
				mode_o = MODE_ABS;
			end
			`CPU_OP_ADC_IMM: begin
				opcode_o = OP_ADC;
				mode_o = MODE_IMM;
			end
			`CPU_OP_SBC_IMM: begin
				opcode_o = OP_SBC;
				mode_o = MODE_IMM;
			end
			`CPU_OP_AND_IMM: begin
				opcode_o = OP_AND;
				mode_o = MODE_IMM;
			end
			`CPU_OP_ORA_IMM: begin
				opcode_o = OP_ORA;
				mode_o = MODE_IMM;
			end
			`CPU_OP_EOR_IMM: begin
				opcode_o = OP_EOR;
				mode_o = MODE_IMM;
			end
			`CPU_OP_JMP_ABS: begin
				opcode_o = OP_JMP;
				mode_o = MODE_ABS;
			end
			`CPU_OP_TAX: opcode_o = OP_TAX;
			`CPU_OP_INX: opcode_o = OP_INX;
			`CPU_OP_SEC: opcode_o = OP_SEC;
			`CPU_OP_CLC: opcode_o = OP_CLC;
			`CPU_OP_BRK: opcode_o = OP_BRK;
			default: opcode_o = OP_ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/cpu_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_pc (
	input  logic           clk_i,
	input  logic           arst_n_i,
	input  logic           inc_i,
	input  logic           load_i,
	input  cpu_pkg::addr_t load_addr_i,
	output cpu_pkg::addr_t pc_o
);

	import cpu_pkg::*;

	addr_t pc;

	// Load wins over increment
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc <= `CPU_RESET_PC;
		end else if (load_i) begin
			pc <= load_addr_i;
		end else if (inc_i) begin
			pc <= pc + addr_t'(1);
		end
	end

	assign pc_o = pc;

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_N - 1:0] data_t;
	typedef logic [`CPU_ADDR_N - 1:0] addr_t;

	// Processor flags, negative in the top bit
	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} status_t;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADC,
		ALU_SBC,
		ALU_AND,
		ALU_ORA,
		ALU_EOR,
		ALU_INC_A
	} alu_func_t;

	typedef enum logic [1:0] {
		A_SEL_ACC,
		A_SEL_X,
		A_SEL_ZERO
	} alu_a_sel_t;

	typedef enum logic {
		B_SEL_DATA,
		B_SEL_ZERO
	} alu_b_sel_t;

	typedef enum logic {
		ADDR_SEL_PC,
		ADDR_SEL_DL
	} addr_sel_t;

	typedef enum logic [3:0] {
		OP_LDA, OP_STA, OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
		OP_TAX, OP_INX, OP_SEC, OP_CLC, OP_JMP, OP_BRK, OP_ILLEGAL
	} opcode_t;

	typedef enum logic [1:0] {
		MODE_IMP,
		MODE_IMM,
		MODE_ABS
	} mode_t;

endpackage

`default_nettype wire

// ==== src/cpu_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_reg #(
	parameter type T = logic [7:0]
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic we_i,
	input  T     d_i,
	output T     q_o
);

	T q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q <= '0;
		end else if (we_i) begin
			q <= d_i;
		end
	end

	assign q_o = q;

endmodule

`default_nettype wire

// ==== src/cpu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  cpu_pkg::opcode_t    opcode_i,
	input  cpu_pkg::mode_t      mode_i,
	output logic                ir_we_o,
	output logic                a_we_o,
	output logic                x_we_o,
	output logic                p_we_o,
	output cpu_pkg::status_t    flags_mask_o,
	output logic                carry_set_o,
	output logic                carry_clr_o,
	output logic                dll_we_o,
	output logic                dlh_we_o,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output cpu_pkg::alu_func_t  alu_func_o,
	output cpu_pkg::alu_a_sel_t alu_a_sel_o,
	output cpu_pkg::alu_b_sel_t alu_b_sel_o,
	output cpu_pkg::addr_sel_t  addr_sel_o,
	output logic                we_o,
	output logic                halted_o
);

	import cpu_pkg::*;

	typedef enum logic [2:0] {
		S_FETCH,
		S_OPER,
		S_ADL,
		S_ADH,
		S_ACCESS,
		S_HALT
	} state_t;

	localparam status_t MASK_NZ = '{n: 1'b1, v: 1'b0, z: 1'b1, c: 1'b0};
	localparam status_t MASK_NVZC = '{n: 1'b1, v: 1'b1, z: 1'b1, c: 1'b1};

	state_t state;
	state_t state_next;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= S_FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		ir_we_o = 1'b0;
		a_we_o = 1'b0;
		x_we_o = 1'b0;
		p_we_o = 1'b0;
		flags_mask_o = '0;
		carry_set_o = 1'b0;
		carry_clr_o = 1'b0;
		dll_we_o = 1'b0;
		dlh_we_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		alu_func_o = ALU_PASS_B;
		alu_a_sel_o = A_SEL_ZERO;
		alu_b_sel_o = B_SEL_DATA;
		addr_sel_o = ADDR_SEL_PC;
		we_o = 1'b0;
		halted_o = 1'b0;

		case (state)
			// Opcode byte is decoded straight off the bus here
			S_FETCH: begin
				ir_we_o = 1'b1;
				pc_inc_o = 1'b1;
				if (opcode_i == OP_BRK || opcode_i == OP_ILLEGAL) begin
					state_next = S_HALT;
				end else if (mode_i == MODE_ABS) begin
					state_next = S_ADL;
				end else begin
					state_next = S_OPER;
				end
			end
			S_OPER: begin
				state_next = S_FETCH;
				pc_inc_o = (mode_i == MODE_IMM);
				alu_a_sel_o = A_SEL_ACC;
				case (opcode_i)
					OP_LDA, OP_AND, OP_ORA, OP_EOR: begin
						a_we_o = 1'b1;
						p_we_o = 1'b1;
						flags_mask_o = MASK_NZ;
						case (opcode_i)
							OP_AND: alu_func_o = ALU_AND;
							OP_ORA: alu_func_o = ALU_ORA;
							OP_EOR: alu_func_o = ALU_EOR;
							default: alu_func_o = ALU_PASS_B;
						endcase
					end
					OP_ADC, OP_SBC: begin
						alu_func_o = (opcode_i == OP_SBC) ? ALU_SBC : ALU_ADC;
						a_we_o = 1'b1;
						p_we_o = 1'b1;
						flags_mask_o = MASK_NVZC;
					end
					// A or zero copies A into X
					OP_TAX: begin
						alu_func_o = ALU_ORA;
						alu_b_sel_o = B_SEL_ZERO;
						x_we_o = 1'b1;
						p_we_o = 1'b1;
						flags_mask_o = MASK_NZ;
					end
					OP_INX: begin
						alu_func_o = ALU_INC_A;
						alu_a_sel_o = A_SEL_X;
						x_we_o = 1'b1;
						p_we_o = 1'b1;
						flags_mask_o = MASK_NZ;
					end
					OP_SEC: begin
						p_we_o = 1'b1;
						carry_set_o = 1'b1;
					end
					OP_CLC: begin
						p_we_o = 1'b1;
						carry_clr_o = 1'b1;
					end
					default: state_next = S_HALT;
				endcase
			end
			S_ADL: begin
				dll_we_o = 1'b1;
				pc_inc_o = 1'b1;
				state_next = S_ADH;
			end
			S_ADH: begin
				dlh_we_o = 1'b1;
				pc_inc_o = 1'b1;
				if (opcode_i == OP_JMP) begin
					pc_load_o = 1'b1;
					state_next = S_FETCH;
				end else begin
					state_next = S_ACCESS;
				end
			end
			S_ACCESS: begin
				addr_sel_o = ADDR_SEL_DL;
				state_next = S_FETCH;
				if (opcode_i == OP_STA) begin
					we_o = 1'b1;
				end else begin
					a_we_o = 1'b1;
					p_we_o = 1'b1;
					flags_mask_o = MASK_NZ;
				end
			end
			default: begin
				halted_o = 1'b1;
				state_next = S_HALT;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;

	localparam int RESET_CYCLES = 8;
	localparam int TEST_COUNT = 8;
	localparam int MAX_INSTR = 20;
	localparam int HALT_HOLD = 10;
	// Worst case per test is four cycles for every instruction
	localparam int TEST_CYCLES = RESET_CYCLES + 2 + 4 * MAX_INSTR + HALT_HOLD + 2;
	localparam int WATCHDOG_CYCLES = 2 * TEST_COUNT * TEST_CYCLES;

	logic                     clk;
	logic                     arst_n;
	logic [`CPU_ADDR_N - 1:0] addr;
	logic [`CPU_DATA_N - 1:0] rd_data;
	logic [`CPU_DATA_N - 1:0] wr_data;
	logic                     we;
	logic                     halted;

	logic [7:0]  mem [0:65535];
	logic [15:0] emit_ptr;
	string       test_name;

	cpu UUT (
		.clk_i(clk), .arst_n_i(arst_n), .addr_o(addr), .data_i(rd_data),
		.data_o(wr_data), .we_o(we), .halted_o(halted)
	);

	// 64 KB memory, combinational read
	assign rd_data = mem[addr];

	always @(posedge clk) begin
		if (we) begin
			mem[addr] <= wr_data;
		end
	end

	always #10 clk = ~clk;

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		fill_byte = a[15:8] ^ a[7:0] ^ 8'hA5;
	endfunction

	function automatic logic [7:0] rand_byte();
		rand_byte = 8'($urandom);
	endfunction

	// Pages keep data apart from code and from each other
	function automatic logic [15:0] rand_addr(input logic [3:0] page);
		rand_addr = {page, 12'($urandom)};
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < 65536; i++) begin
			mem[i] = fill_byte(16'(i));
		end
	endtask

	task automatic check_value(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch in %s", test_name);
		end
	endtask

	task automatic emit_byte(input logic [7:0] b);
		mem[emit_ptr] = b;
		emit_ptr = emit_ptr + 16'd1;
	endtask

	task automatic emit_imm(input logic [7:0] op, input logic [7:0] val);
		emit_byte(op);
		emit_byte(val);
	endtask

	task automatic emit_abs(input logic [7:0] op, input logic [15:0] a);
		emit_byte(op);
		emit_byte(a[7:0]);
		emit_byte(a[15:8]);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		fill_memory();
		emit_ptr = `CPU_RESET_PC;
	endtask

	task automatic run_program();
		// Core state while still in reset
		@(negedge clk);
		check_value("we_o in reset", 16'd0, 16'(we));
		check_value("halted_o in reset", 16'd0, 16'(halted));
		check_value("addr_o in reset", `CPU_RESET_PC, addr);
		@(posedge clk);
		arst_n <= 1'b1;
		do begin
			@(negedge clk);
		end while (halted !== 1'b1);
	endtask

	task automatic test_load_store();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] dst1;
		logic [15:0] src;
		logic [15:0] dst2;
		begin_test("load_store");
		a = rand_byte();
		b = rand_byte();
		dst1 = rand_addr(4'h8);
		src = rand_addr(4'h9);
		dst2 = rand_addr(4'hA);
		mem[src] = b;
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_abs(`CPU_OP_STA_ABS, dst1);
		emit_abs(`CPU_OP_LDA_ABS, src);
		emit_abs(`CPU_OP_STA_ABS, dst2);
		emit_byte(`CPU_OP_BRK);
		run_program();
		check_value("immediate store", 16'(a), 16'(mem[dst1]));
		check_value("absolute copy", 16'(b), 16'(mem[dst2]));
	endtask

	task automatic test_add_sub(input bit sub);
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] dst;
		int          expected;
		begin_test(sub ? "sbc" : "adc");
		a = rand_byte();
		b = rand_byte();
		dst = rand_addr(4'h8);
		emit_byte(sub ? `CPU_OP_SEC : `CPU_OP_CLC);
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(sub ? `CPU_OP_SBC_IMM : `CPU_OP_ADC_IMM, b);
		emit_abs(`CPU_OP_STA_ABS, dst);
		emit_byte(`CPU_OP_BRK);
		run_program();
		// Carry set means no borrow
		expected = sub ? (int'(a) - int'(b)) : (int'(a) + int'(b));
		check_value("result", 16'(expected & 8'hFF), 16'(mem[dst]));
	endtask

	task automatic test_carry_chain();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] r [4];
		int          sum;
		begin_test("carry_chain");
		// Both operands at least 0x80 so the add overflows
		a = 8'h80 | rand_byte();
		b = 8'h80 | rand_byte();
		sum = int'(a) + int'(b);
		for (int i = 0; i < 4; i++) begin
			r[i] = rand_addr(4'h8 + 4'(i));
		end
		emit_byte(`CPU_OP_CLC);
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(`CPU_OP_ADC_IMM, b);
		emit_abs(`CPU_OP_STA_ABS, r[0]);
		emit_imm(`CPU_OP_LDA_IMM, 8'h00);
		emit_imm(`CPU_OP_ADC_IMM, 8'h00);
		emit_abs(`CPU_OP_STA_ABS, r[1]);
		// Overflow again so CLC has a carry to clear
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(`CPU_OP_ADC_IMM, b);
		emit_byte(`CPU_OP_CLC);
		emit_imm(`CPU_OP_LDA_IMM, 8'h00);
		emit_imm(`CPU_OP_ADC_IMM, 8'h00);
		emit_abs(`CPU_OP_STA_ABS, r[2]);
		emit_byte(`CPU_OP_SEC);
		emit_imm(`CPU_OP_LDA_IMM, 8'h00);
		emit_imm(`CPU_OP_ADC_IMM, 8'h00);
		emit_abs(`CPU_OP_STA_ABS, r[3]);
		emit_byte(`CPU_OP_BRK);
		run_program();
		check_value("overflowing sum", 16'(sum & 8'hFF), 16'(mem[r[0]]));
		check_value("carry out", 16'(sum > 255), 16'(mem[r[1]]));
		check_value("after CLC", 16'd0, 16'(mem[r[2]]));
		check_value("after SEC", 16'd1, 16'(mem[r[3]]));
	endtask

	task automatic test_logic_and_x();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  c;
		logic [15:0] r [4];
		begin_test("logic_and_x");
		a = rand_byte();
		b = rand_byte();
		c = rand_byte();
		for (int i = 0; i < 4; i++) begin
			r[i] = rand_addr(4'h8 + 4'(i));
		end
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(`CPU_OP_AND_IMM, b);
		emit_abs(`CPU_OP_STA_ABS, r[0]);
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(`CPU_OP_ORA_IMM, b);
		emit_abs(`CPU_OP_STA_ABS, r[1]);
		emit_imm(`CPU_OP_LDA_IMM, a);
		emit_imm(`CPU_OP_EOR_IMM, b);
		emit_abs(`CPU_OP_STA_ABS, r[2]);
		// INX touches X only, so A must survive
		emit_imm(`CPU_OP_LDA_IMM, c);
		emit_byte(`CPU_OP_TAX);
		emit_byte(`CPU_OP_INX);
		emit_byte(`CPU_OP_CLC);
		emit_imm(`CPU_OP_ADC_IMM, 8'h00);
		emit_abs(`CPU_OP_STA_ABS, r[3]);
		emit_byte(`CPU_OP_BRK);
		run_program();
		check_value("and", 16'(a & b), 16'(mem[r[0]]));
		check_value("ora", 16'(a | b), 16'(mem[r[1]]));
		check_value("eor", 16'(a ^ b), 16'(mem[r[2]]));
		check_value("acc after tax inx", 16'(c), 16'(mem[r[3]]));
	endtask

	task automatic test_jump();
		logic [7:0]  v;
		logic [15:0] marker;
		logic [15:0] dst;
		logic [15:0] target;
		begin_test("jmp");
		v = rand_byte();
		marker = rand_addr(4'hB);
		dst = rand_addr(4'hC);
		emit_imm(`CPU_OP_LDA_IMM, v);
		// Jump over the three byte marker store
		target = emit_ptr + 16'd6;
		emit_abs(`CPU_OP_JMP_ABS, target);
		emit_abs(`CPU_OP_STA_ABS, marker);
		emit_abs(`CPU_OP_STA_ABS, dst);
		emit_byte(`CPU_OP_BRK);
		run_program();
		check_value("skipped marker", 16'(fill_byte(marker)), 16'(mem[marker]));
		check_value("store at target", 16'(v), 16'(mem[dst]));
	endtask

	task automatic test_halt(input string name, input logic [7:0] stop_op);
		logic [7:0]  v;
		logic [15:0] guard;
		begin_test(name);
		guard = rand_addr(4'hD);
		// Never the fill byte, so a stray store shows
		v = ~fill_byte(guard);
		emit_imm(`CPU_OP_LDA_IMM, v);
		emit_byte(stop_op);
		emit_abs(`CPU_OP_STA_ABS, guard);
		emit_byte(`CPU_OP_BRK);
		run_program();
		repeat (HALT_HOLD) begin
			@(negedge clk);
			check_value("we_o while halted", 16'd0, 16'(we));
			check_value("halted_o held", 16'd1, 16'(halted));
		end
		check_value("guarded byte", 16'(fill_byte(guard)), 16'(mem[guard]));
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		void'($urandom(48411));
		fill_memory();
		test_load_store();
		test_add_sub(1'b0);
		test_add_sub(1'b1);
		test_carry_chain();
		test_logic_and_x();
		test_jump();
		test_halt("halt_brk", `CPU_OP_BRK);
		test_halt("halt_illegal", 8'h02);
		$display("TEST PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired: the core did not halt in time in %s", test_name);
		$display("TEST FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire
